//--- Bender.yml
package:
  name: udp_echo

dependencies: {}

sources:
  # Package first, then the blocks, then the top level
  - rtl/udp_echo_pkg.sv
  - rtl/udp_port_filter.sv
  - rtl/udp_reply_header.sv
  - rtl/payload_fifo.sv
  - rtl/first_byte_led.sv
  - rtl/udp_echo_core.sv

  - target: test
    files:
      - tests/udp_echo_tb.sv

//--- rtl/first_byte_led.sv
/*
 * LED capture of the first payload byte of each reply datagram
 */
`timescale 1ns/1ps
`default_nettype none

module first_byte_led
    import udp_echo_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  payload_beat_t         beat,
    input  wire                   valid,
    input  wire                   ready,
    output logic [LED_WIDTH-1:0]  led
);

    logic in_frame;
    logic xfer;

    assign xfer = valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (xfer) begin
            if (!in_frame) begin
                led      <= beat.data[LED_WIDTH-1:0];
                in_frame <= 1'b1;
            end
            // Last beat wins, so a one-byte datagram leaves the flag clear
            if (beat.last) begin
                in_frame <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/payload_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO for payload beats,
 * data, last and user stored together in one entry
 */
`timescale 1ns/1ps
`default_nettype none

module payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  wire           clk,
    input  wire           rst,

    input  payload_beat_t in_beat,
    input  wire           in_valid,
    output logic          in_ready,

    output payload_beat_t out_beat,
    output logic          out_valid,
    input  wire           out_ready
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    payload_beat_t mem [FIFO_DEPTH];

    // Extra top bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic empty;
    logic full;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign out_valid = !empty;

    // When full a slot still opens if the head is read on this edge
    assign in_ready = !full || out_ready;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Head of queue visible without a read request
    assign out_beat = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_echo_core.sv
/*
 * UDP echo responder top level: port filter, reply header stage,
 * payload FIFO and first-byte LED capture
 */
`timescale 1ns/1ps
`default_nettype none

module udp_echo_core
    import udp_echo_pkg::*;
#(
    parameter udp_port_t ECHO_PORT  = 16'd1234,
    parameter ip_addr_t  LOCAL_IP   = {8'd192, 8'd168, 8'd0, 8'd20},
    parameter int        FIFO_DEPTH = 16
) (
    input  wire                  clk,
    input  wire                  rst,

    // Decoded request from the UDP stack
    input  udp_hdr_t             in_hdr,
    input  wire                  in_hdr_valid,
    output logic                 in_hdr_ready,
    input  payload_beat_t        in_pay,
    input  wire                  in_pay_valid,
    output logic                 in_pay_ready,

    // Reply back to the UDP stack
    output udp_hdr_t             out_hdr,
    output logic                 out_hdr_valid,
    input  wire                  out_hdr_ready,
    output payload_beat_t        out_pay,
    output logic                 out_pay_valid,
    input  wire                  out_pay_ready,

    output logic [LED_WIDTH-1:0] led
);

    udp_hdr_t      req_hdr;
    logic          req_hdr_valid;
    logic          req_hdr_ready;

    payload_beat_t fifo_in;
    logic          fifo_in_valid;
    logic          fifo_in_ready;

    udp_port_filter #(
        .ECHO_PORT (ECHO_PORT)
    ) u_filter (
        .clk           (clk),
        .rst           (rst),
        .in_hdr        (in_hdr),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_pay        (in_pay),
        .in_pay_valid  (in_pay_valid),
        .in_pay_ready  (in_pay_ready),
        .req_hdr       (req_hdr),
        .req_hdr_valid (req_hdr_valid),
        .req_hdr_ready (req_hdr_ready),
        .fifo_in       (fifo_in),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready)
    );

    udp_reply_header #(
        .LOCAL_IP (LOCAL_IP)
    ) u_reply (
        .clk           (clk),
        .rst           (rst),
        .req_hdr       (req_hdr),
        .req_hdr_valid (req_hdr_valid),
        .req_hdr_ready (req_hdr_ready),
        .out_hdr       (out_hdr),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready)
    );

    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_beat  (out_pay),
        .out_valid (out_pay_valid),
        .out_ready (out_pay_ready)
    );

    // Watches the reply payload as it leaves
    first_byte_led u_led (
        .clk   (clk),
        .rst   (rst),
        .beat  (out_pay),
        .valid (out_pay_valid),
        .ready (out_pay_ready),
        .led   (led)
    );

endmodule

`default_nettype wire

//--- rtl/udp_echo_pkg.sv
/*
 * Shared types for the UDP echo responder: address and port types,
 * the datagram header and payload beat structs, the filter state enum
 * and the fixed protocol constants
 */
`default_nettype none

package udp_echo_pkg;

    // IPv4 address, first octet in the top byte
    typedef logic [31:0] ip_addr_t;

    typedef logic [15:0] udp_port_t;

    // Decoded UDP header as delivered by the UDP stack
    // Same layout for request and reply
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        logic [7:0] ttl;
        udp_port_t src_port;
        udp_port_t dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One byte of payload with its framing bits
    typedef struct packed {
        logic [7:0] data;
        // Final byte of the datagram
        logic       last;
        // Error flag from the stack, passed through untouched
        logic       user;
    } payload_beat_t;

    // Filter decision for the datagram in flight
    typedef enum logic [1:0] {
        FILTER_IDLE = 2'd0,
        FILTER_PASS = 2'd1,
        FILTER_DROP = 2'd2
    } filter_state_t;

    // TTL stamped into every reply
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Number of board LEDs
    localparam int LED_WIDTH = 4;

endpackage

`default_nettype wire

//--- rtl/udp_port_filter.sv
/*
 * Destination port filter: forwards matching headers to the reply stage,
 * passes matching payload on to the FIFO and swallows everything else
 */
`timescale 1ns/1ps
`default_nettype none

module udp_port_filter
    import udp_echo_pkg::*;
#(
    parameter udp_port_t ECHO_PORT = 16'd1234
) (
    input  wire           clk,
    input  wire           rst,

    input  udp_hdr_t      in_hdr,
    input  wire           in_hdr_valid,
    output logic          in_hdr_ready,

    input  payload_beat_t in_pay,
    input  wire           in_pay_valid,
    output logic          in_pay_ready,

    output udp_hdr_t      req_hdr,
    output logic          req_hdr_valid,
    input  wire           req_hdr_ready,

    output payload_beat_t fifo_in,
    output logic          fifo_in_valid,
    input  wire           fifo_in_ready
);

    filter_state_t state;

    logic match;
    logic hdr_xfer;
    logic last_xfer;

    assign match = (in_hdr.dst_port == ECHO_PORT);

    // Header side, only accepted between datagrams
    always_comb begin
        if (state == FILTER_IDLE) begin
            in_hdr_ready = !match || req_hdr_ready;
        end else begin
            in_hdr_ready = 1'b0;
        end
    end

    // Only echo traffic reaches the reply stage
    assign req_hdr       = in_hdr;
    assign req_hdr_valid = (state == FILTER_IDLE) && in_hdr_valid && match;

    // Payload goes straight through, steered by the stored decision
    assign fifo_in       = in_pay;
    assign fifo_in_valid = (state == FILTER_PASS) && in_pay_valid;

    always_comb begin
        case (state)
            FILTER_PASS: in_pay_ready = fifo_in_ready;
            FILTER_DROP: in_pay_ready = 1'b1;
            default:     in_pay_ready = 1'b0;
        endcase
    end

    assign hdr_xfer  = in_hdr_valid && in_hdr_ready;
    assign last_xfer = in_pay_valid && in_pay_ready && in_pay.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILTER_IDLE;
        end else begin
            case (state)
                FILTER_IDLE: begin
                    if (hdr_xfer) begin
                        state <= match ? FILTER_PASS : FILTER_DROP;
                    end
                end
                FILTER_PASS, FILTER_DROP: begin
                    // Back to idle once the whole payload is through
                    if (last_xfer) begin
                        state <= FILTER_IDLE;
                    end
                end
                default: state <= FILTER_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_reply_header.sv
/*
 * Reply header stage: single-entry register slice that turns an
 * accepted request header into its reply and holds it for the sink
 */
`timescale 1ns/1ps
`default_nettype none

module udp_reply_header
    import udp_echo_pkg::*;
#(
    parameter ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd0, 8'd20}
) (
    input  wire      clk,
    input  wire      rst,

    input  udp_hdr_t req_hdr,
    input  wire      req_hdr_valid,
    output logic     req_hdr_ready,

    output udp_hdr_t out_hdr,
    output logic     out_hdr_valid,
    input  wire      out_hdr_ready
);

    logic     full;
    udp_hdr_t hdr_reg;
    udp_hdr_t reply;

    logic load;
    logic take;

    // Reply form of the incoming request
    always_comb begin
        reply.src_ip   = LOCAL_IP;
        reply.dst_ip   = req_hdr.src_ip;
        reply.ttl      = REPLY_TTL;
        reply.src_port = req_hdr.dst_port;
        reply.dst_port = req_hdr.src_port;
        reply.length   = req_hdr.length;
        // No UDP checksum on the reply
        reply.checksum = 16'd0;
    end

    assign take = full && out_hdr_ready;

    // Free slot, or the held entry leaves on this same edge
    assign req_hdr_ready = !full || out_hdr_ready;
    assign load          = req_hdr_valid && req_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hdr_reg <= reply;
        end
    end

    assign out_hdr       = hdr_reg;
    assign out_hdr_valid = full;

endmodule

`default_nettype wire

//--- sources.f
rtl/udp_echo_pkg.sv
rtl/udp_port_filter.sv
rtl/udp_reply_header.sv
rtl/payload_fifo.sv
rtl/first_byte_led.sv
rtl/udp_echo_core.sv
tests/udp_echo_tb.sv

//--- tests/udp_echo_tb.sv
/*
 * Testbench for the UDP echo responder: stimulus table, LCG payloads,
 * random output stalls, reply checks and a cycle-count timeout
 */
`timescale 1ns/1ps
`default_nettype none

module udp_echo_tb
    import udp_echo_pkg::*;
;

    localparam int          NUM_ROWS   = 8;
    localparam int          MAX_LEN    = 40;
    localparam int          FIFO_DEPTH = 16;
    localparam udp_port_t   ECHO_PORT  = 16'd1234;
    localparam ip_addr_t    LOCAL_IP   = 32'hC0A80014;
    localparam logic [31:0] SEED       = 32'd43137;

    // One datagram per row
    typedef struct packed {
        ip_addr_t   src_ip;
        udp_port_t  dst_port;
        udp_port_t  src_port;
        logic [7:0] len;
        logic       err;
        logic       stall;
    } row_t;

    logic          clk;
    logic          rst;
    udp_hdr_t      in_hdr;
    logic          in_hdr_valid;
    logic          in_hdr_ready;
    payload_beat_t in_pay;
    logic          in_pay_valid;
    logic          in_pay_ready;
    udp_hdr_t      out_hdr;
    logic          out_hdr_valid;
    logic          out_hdr_ready;
    payload_beat_t out_pay;
    logic          out_pay_valid;
    logic          out_pay_ready;
    logic [3:0]    led;

    row_t          stim [NUM_ROWS];
    logic [7:0]    pay_bytes [NUM_ROWS][MAX_LEN];
    udp_hdr_t      exp_hdr [$];
    payload_beat_t exp_pay [$];
    logic [3:0]    exp_led [$];
    logic          stall_mode;
    logic          saw_pay_stall;
    int            cycle_limit;

    udp_echo_core u_dut (
        .clk           (clk),
        .rst           (rst),
        .in_hdr        (in_hdr),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_pay        (in_pay),
        .in_pay_valid  (in_pay_valid),
        .in_pay_ready  (in_pay_ready),
        .out_hdr       (out_hdr),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_pay       (out_pay),
        .out_pay_valid (out_pay_valid),
        .out_pay_ready (out_pay_ready),
        .led           (led)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic row_t make_row(input ip_addr_t ip, input udp_port_t dport,
                                      input udp_port_t sport, input int len,
                                      input logic err, input logic stall);
        row_t r;
        r.src_ip   = ip;
        r.dst_port = dport;
        r.src_port = sport;
        r.len      = len[7:0];
        r.err      = err;
        r.stall    = stall;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [135:0] got,
                               input logic [135:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run aborted");
    endtask

    // Push one header and its payload, holding valid until each transfer
    task automatic send_row(input int r);
        in_hdr.src_ip   = stim[r].src_ip;
        in_hdr.dst_ip   = LOCAL_IP;
        in_hdr.ttl      = 8'd100 + 8'(r);
        in_hdr.src_port = stim[r].src_port;
        in_hdr.dst_port = stim[r].dst_port;
        in_hdr.length   = 16'd8 + 16'(stim[r].len);
        in_hdr.checksum = 16'hA5A5 ^ 16'(r);
        in_hdr_valid    = 1'b1;
        @(negedge clk);
        while (!in_hdr_ready) @(negedge clk);
        @(posedge clk);
        #2;
        in_hdr_valid = 1'b0;
        for (int b = 0; b < stim[r].len; b++) begin
            in_pay.data  = pay_bytes[r][b];
            in_pay.last  = (b == stim[r].len - 1);
            in_pay.user  = stim[r].err && (b == stim[r].len - 1);
            in_pay_valid = 1'b1;
            @(negedge clk);
            while (!in_pay_ready) begin
                if (stim[r].stall && stim[r].len > FIFO_DEPTH) begin
                    saw_pay_stall = 1'b1;
                end
                @(negedge clk);
            end
            @(posedge clk);
            #2;
        end
        in_pay_valid = 1'b0;
    endtask

    // Output side: readies, header and payload checks, LED check
    initial begin : receiver
        logic [31:0]   rs;
        udp_hdr_t      eh;
        payload_beat_t eb;
        logic [3:0]    led_exp;
        logic          led_pending;
        logic          stall_now;
        rs          = SEED;
        led_pending = 1'b0;
        stall_now   = 1'b0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            #2;
            if (stall_now) begin
                // Ready one cycle in four
                rs            = lcg_next(rs);
                out_hdr_ready = &rs[31:30];
                rs            = lcg_next(rs);
                out_pay_ready = &rs[31:30];
            end else begin
                out_hdr_ready = 1'b1;
                out_pay_ready = 1'b1;
            end
            @(negedge clk);
            // Stall setting of the row in flight, used from the next edge
            stall_now = stall_mode;
            if (led_pending) begin
                check_value("led", led, led_exp);
                led_pending = 1'b0;
            end
            if (out_hdr_valid && out_hdr_ready) begin
                if (exp_hdr.size() == 0) begin
                    fail_run("A reply header came out with no matching request");
                end
                eh = exp_hdr.pop_front();
                check_value("out_hdr.src_ip", out_hdr.src_ip, eh.src_ip);
                check_value("out_hdr.dst_ip", out_hdr.dst_ip, eh.dst_ip);
                check_value("out_hdr.ttl", out_hdr.ttl, eh.ttl);
                check_value("out_hdr.src_port", out_hdr.src_port, eh.src_port);
                check_value("out_hdr.dst_port", out_hdr.dst_port, eh.dst_port);
                check_value("out_hdr.length", out_hdr.length, eh.length);
                check_value("out_hdr.checksum", out_hdr.checksum, eh.checksum);
            end
            if (out_pay_valid && out_pay_ready) begin
                if (exp_pay.size() == 0) begin
                    fail_run("A payload byte came out that belongs to no echoed datagram");
                end
                eb = exp_pay.pop_front();
                check_value("out_pay.data", out_pay.data, eb.data);
                check_value("out_pay.last", out_pay.last, eb.last);
                check_value("out_pay.user", out_pay.user, eb.user);
                if (eb.last) begin
                    led_exp     = exp_led.pop_front();
                    led_pending = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                fail_run("Timeout: the replies did not finish within the cycle limit");
            end
        end
    end

    initial begin : main
        logic [31:0]   ps;
        int            total;
        udp_hdr_t      eh;
        payload_beat_t eb;
        logic [3:0]    last_led;
        rst           = 1'b1;
        in_hdr        = '0;
        in_hdr_valid  = 1'b0;
        in_pay        = '0;
        in_pay_valid  = 1'b0;
        out_hdr_ready = 1'b0;
        out_pay_ready = 1'b0;
        stall_mode    = 1'b0;
        saw_pay_stall = 1'b0;
        last_led      = 4'h0;

        stim[0] = make_row(32'h0A000001, 16'd1234, 16'd5000, 1, 1'b0, 1'b0);
        stim[1] = make_row(32'h0A000002, 16'd80, 16'd5001, 12, 1'b0, 1'b0);
        stim[2] = make_row(32'hAC100509, 16'd1234, 16'd40000, 40, 1'b0, 1'b1);
        stim[3] = make_row(32'h0A000003, 16'd1235, 16'd6000, 20, 1'b1, 1'b1);
        stim[4] = make_row(32'hC0A80007, 16'd1234, 16'd7, 17, 1'b1, 1'b0);
        stim[5] = make_row(32'h0A010203, 16'd1234, 16'd53, 33, 1'b0, 1'b1);
        stim[6] = make_row(32'h0A000009, 16'd1234, 16'd9999, 8, 1'b1, 1'b0);
        // Dropped datagram last, so the final LED check covers a drop
        stim[7] = make_row(32'h08080808, 16'd4321, 16'd1234, 5, 1'b0, 1'b0);

        // Payloads and the expected replies of matching rows
        ps    = SEED;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int b = 0; b < stim[r].len; b++) begin
                ps              = lcg_next(ps);
                pay_bytes[r][b] = ps[23:16];
                if (stim[r].dst_port == ECHO_PORT) begin
                    eb.data = ps[23:16];
                    eb.last = (b == stim[r].len - 1);
                    eb.user = stim[r].err && (b == stim[r].len - 1);
                    exp_pay.push_back(eb);
                end
            end
            total += stim[r].len;
            if (stim[r].dst_port == ECHO_PORT) begin
                eh.src_ip   = LOCAL_IP;
                eh.dst_ip   = stim[r].src_ip;
                eh.ttl      = 8'd64;
                eh.src_port = stim[r].dst_port;
                eh.dst_port = stim[r].src_port;
                eh.length   = 16'd8 + 16'(stim[r].len);
                eh.checksum = 16'd0;
                exp_hdr.push_back(eh);
                exp_led.push_back(pay_bytes[r][0][3:0]);
                last_led = pay_bytes[r][0][3:0];
            end
        end
        cycle_limit = 4 * total + 50 * NUM_ROWS;

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #2;
            if (i > 0) begin
                check_value("out_hdr_valid", out_hdr_valid, 1'b0);
                check_value("out_pay_valid", out_pay_valid, 1'b0);
                check_value("in_pay_ready", in_pay_ready, 1'b0);
                check_value("led", led, 4'h0);
            end
        end
        rst = 1'b0;
        @(negedge clk);
        check_value("out_hdr_valid", out_hdr_valid, 1'b0);
        check_value("out_pay_valid", out_pay_valid, 1'b0);
        check_value("led", led, 4'h0);
        @(posedge clk);
        #2;

        for (int r = 0; r < NUM_ROWS; r++) begin
            stall_mode = stim[r].stall;
            send_row(r);
        end
        stall_mode = 1'b0;

        while (exp_hdr.size() != 0 || exp_pay.size() != 0) @(negedge clk);
        repeat (5) @(negedge clk);

        // Nothing left over once every reply is out
        check_value("out_hdr_valid", out_hdr_valid, 1'b0);
        check_value("out_pay_valid", out_pay_valid, 1'b0);
        check_value("led", led, last_led);
        check_value("in_pay_ready_seen_low", saw_pay_stall, 1'b1);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
